/* include/dbg_cfg.svh */
//////////////////////////////////////////////////////////////////////
// Debug chain configuration
// Widths, command field positions, module IDs and opcodes
//////////////////////////////////////////////////////////////////////
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// Chain and payload widths
`define DBG_DATAREG_LEN   32
`define DBG_MODULE_ID_LEN 2
`define DBG_OP_W          3
`define DBG_ADDR_W        8
`define DBG_DATA_W        16
// 16 data bits plus two status bits
`define DBG_OUT_LEN       18

// Positions in the top shift register
`define DBG_SEL_BIT       31
`define DBG_ID_MSB        30
`define DBG_CMD_MSB       30
`define DBG_CMD_LSB       4
`define DBG_CMD_W         27

// Positions inside cmd_i, i.e. shift register bits 30:4
`define DBG_CMD_OP_MSB    26
`define DBG_CMD_OP_LSB    24
`define DBG_CMD_ADDR_MSB  23
`define DBG_CMD_ADDR_LSB  16
`define DBG_CMD_DATA_MSB  15
`define DBG_CMD_DATA_LSB  0

// Module IDs, code 2 selects nothing as well
`define DBG_ID_BUS        0
`define DBG_ID_CPU        1
`define DBG_ID_RSVD       3

// Module command opcodes
`define DBG_OP_NOP        0
`define DBG_OP_WRITE      1
`define DBG_OP_READ       2
`define DBG_OP_STALL      3

`endif

/* hdl/dbg_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Debug subsystem types
// Opcode and module-ID enums, request payloads of the two modules
//////////////////////////////////////////////////////////////////////

`include "dbg_cfg.svh"

package dbg_pkg;

  // Module command opcodes, bits 30:28 of a module command
  typedef enum logic [`DBG_OP_W-1:0] {
    OP_NOP   = `DBG_OP_NOP,
    OP_WRITE = `DBG_OP_WRITE,
    OP_READ  = `DBG_OP_READ,
    OP_STALL = `DBG_OP_STALL
  } dbg_op_e;

  // Module IDs carried by a select command
  typedef enum logic [`DBG_MODULE_ID_LEN-1:0] {
    ID_BUS  = `DBG_ID_BUS,
    ID_CPU  = `DBG_ID_CPU,
    ID_RSVD = `DBG_ID_RSVD
  } dbg_mod_id_e;

  // Single bus access, 25 bits
  typedef struct packed {
    logic                   we;
    logic [`DBG_ADDR_W-1:0] addr;
    logic [`DBG_DATA_W-1:0] wdata;
  } bus_req_t;

  // Special-register access on the stalled core, 25 bits
  typedef struct packed {
    logic                   we;
    logic [`DBG_ADDR_W-1:0] reg_addr;
    logic [`DBG_DATA_W-1:0] wdata;
  } cpu_req_t;

endpackage

/* hdl/dbg_req_slot.sv */
//////////////////////////////////////////////////////////////////////
// One-entry request slot
// Holds a single payload between a valid/ready push and pop
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dbg_req_slot #(
  parameter type T = logic
) (
  input  logic tck_i,
  input  logic tlr_i,
  // Push side
  input  logic in_valid_i,
  input  T     in_data_i,
  output logic in_ready_o,
  // Pop side
  output logic out_valid_o,
  output T     out_data_o,
  input  logic out_ready_i
);

  logic full;
  T     data_q;

  // Ready only when empty, so no push and pop in one cycle
  assign in_ready_o  = ~full;
  assign out_valid_o = full;
  assign out_data_o  = data_q;

  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      full   <= 1'b0;
      data_q <= '0;
    end else if (in_valid_i && in_ready_o) begin
      // Payload stays put until the pop handshake
      full   <= 1'b1;
      data_q <= in_data_i;
    end else if (full && out_ready_i) begin
      full <= 1'b0;
    end
  end

endmodule

/* hdl/dbg_bus_module.sv */
//////////////////////////////////////////////////////////////////////
// Bus-access debug module
// Single 16-bit reads and writes, read data returned on TDO
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dbg_cfg.svh"

module dbg_bus_module (
  input  logic                   tck_i,
  input  logic                   tlr_i,
  // Chain side
  input  logic                   tdi_i,
  output logic                   tdo_o,
  input  logic                   shift_dr_i,
  input  logic                   capture_dr_i,
  input  logic                   cmd_update_i,
  input  logic                   module_select_i,
  input  logic [`DBG_CMD_W-1:0]  cmd_i,
  output logic                   inhibit_o,
  // System bus
  output logic                   bus_req_valid_o,
  input  logic                   bus_req_ready_i,
  output logic                   bus_we_o,
  output logic [`DBG_ADDR_W-1:0] bus_addr_o,
  output logic [`DBG_DATA_W-1:0] bus_wdata_o,
  input  logic                   bus_rsp_valid_i,
  input  logic [`DBG_DATA_W-1:0] bus_rdata_i
);

  import dbg_pkg::*;

  dbg_op_e                 cmd_op;
  logic                    access_cmd;
  logic                    push_valid;
  logic                    push_ready;
  bus_req_t                push_req;
  bus_req_t                bus_req;
  logic                    busy;
  logic                    rd_pending;
  logic [`DBG_DATA_W-1:0]  rdata_q;
  logic [`DBG_OUT_LEN-1:0] out_sr;

  //////////////////////////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////////////////////////

  assign cmd_op = dbg_op_e'(cmd_i[`DBG_CMD_OP_MSB:`DBG_CMD_OP_LSB]);

  // NOP and STALL fall through with no effect
  assign access_cmd = cmd_update_i && module_select_i &&
                      (cmd_op == OP_WRITE || cmd_op == OP_READ);

  // A command arriving while busy is dropped
  assign push_valid     = access_cmd && !busy;
  assign push_req.we    = (cmd_op == OP_WRITE);
  assign push_req.addr  = cmd_i[`DBG_CMD_ADDR_MSB:`DBG_CMD_ADDR_LSB];
  assign push_req.wdata = cmd_i[`DBG_CMD_DATA_MSB:`DBG_CMD_DATA_LSB];

  dbg_req_slot #(
    .T(bus_req_t)
  ) i_slot (
    .tck_i      (tck_i),
    .tlr_i      (tlr_i),
    .in_valid_i (push_valid),
    .in_data_i  (push_req),
    .in_ready_o (push_ready),
    .out_valid_o(bus_req_valid_o),
    .out_data_o (bus_req),
    .out_ready_i(bus_req_ready_i)
  );

  assign bus_we_o    = bus_req.we;
  assign bus_addr_o  = bus_req.addr;
  assign bus_wdata_o = bus_req.wdata;

  //////////////////////////////////////////////////////////////////////
  // Busy tracking and response capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      busy       <= 1'b0;
      rd_pending <= 1'b0;
      rdata_q    <= '0;
    end else if (push_valid && push_ready) begin
      busy       <= 1'b1;
      rd_pending <= ~push_req.we;
    end else if (busy && bus_rsp_valid_i) begin
      // Response ends the transaction, rdata only matters for reads
      busy       <= 1'b0;
      rd_pending <= 1'b0;
      if (rd_pending) begin
        rdata_q <= bus_rdata_i;
      end
    end
  end

  // Hold the module ID until the response is back
  assign inhibit_o = busy;

  // Output register, {read data, error, busy}
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      out_sr <= '0;
    end else if (capture_dr_i && module_select_i) begin
      out_sr <= {rdata_q, 1'b0, busy};
    end else if (shift_dr_i && module_select_i) begin
      out_sr <= {tdi_i, out_sr[`DBG_OUT_LEN-1:1]};
    end
  end

  assign tdo_o = out_sr[0];

endmodule

/* hdl/dbg_cpu_module.sv */
//////////////////////////////////////////////////////////////////////
// CPU debug module
// Stall and breakpoint control, register access on a stalled core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dbg_cfg.svh"

module dbg_cpu_module (
  input  logic                   tck_i,
  input  logic                   tlr_i,
  // Chain side
  input  logic                   tdi_i,
  output logic                   tdo_o,
  input  logic                   shift_dr_i,
  input  logic                   capture_dr_i,
  input  logic                   cmd_update_i,
  input  logic                   module_select_i,
  input  logic [`DBG_CMD_W-1:0]  cmd_i,
  output logic                   inhibit_o,
  // Core side
  input  logic                   cpu_bp_i,
  output logic                   cpu_stall_o,
  output logic                   cpu_stb_o,
  output logic                   cpu_we_o,
  output logic [`DBG_ADDR_W-1:0] cpu_addr_o,
  output logic [`DBG_DATA_W-1:0] cpu_data_o,
  input  logic                   cpu_ack_i,
  input  logic [`DBG_DATA_W-1:0] cpu_data_i
);

  import dbg_pkg::*;

  dbg_op_e                 cmd_op;
  logic                    my_cmd;
  logic                    push_valid;
  logic                    push_ready;
  cpu_req_t                push_req;
  cpu_req_t                cpu_req;
  logic                    stall_q;
  logic                    bp_flag;
  logic [`DBG_DATA_W-1:0]  rdata_q;
  logic [`DBG_OUT_LEN-1:0] out_sr;

  //////////////////////////////////////////////////////////////////////
  // Command decode and register access
  //////////////////////////////////////////////////////////////////////

  assign cmd_op = dbg_op_e'(cmd_i[`DBG_CMD_OP_MSB:`DBG_CMD_OP_LSB]);
  assign my_cmd = cmd_update_i && module_select_i;

  // Access only on a stalled core, nothing while one is in flight
  assign push_valid = my_cmd && stall_q &&
                      (cmd_op == OP_WRITE || cmd_op == OP_READ);

  assign push_req.we       = (cmd_op == OP_WRITE);
  assign push_req.reg_addr = cmd_i[`DBG_CMD_ADDR_MSB:`DBG_CMD_ADDR_LSB];
  assign push_req.wdata    = cmd_i[`DBG_CMD_DATA_MSB:`DBG_CMD_DATA_LSB];

  // Ack pops the slot, so the strobe drops the cycle after it
  dbg_req_slot #(
    .T(cpu_req_t)
  ) i_slot (
    .tck_i      (tck_i),
    .tlr_i      (tlr_i),
    .in_valid_i (push_valid),
    .in_data_i  (push_req),
    .in_ready_o (push_ready),
    .out_valid_o(cpu_stb_o),
    .out_data_o (cpu_req),
    .out_ready_i(cpu_ack_i)
  );

  assign cpu_we_o   = cpu_req.we;
  assign cpu_addr_o = cpu_req.reg_addr;
  assign cpu_data_o = cpu_req.wdata;

  // Busy is exactly the slot being full
  assign inhibit_o = ~push_ready;

  //////////////////////////////////////////////////////////////////////
  // Stall, breakpoint and read data
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      stall_q <= 1'b0;
      bp_flag <= 1'b0;
    end else if (cpu_bp_i) begin
      // Breakpoint wins over a stall command in the same cycle
      stall_q <= 1'b1;
      bp_flag <= 1'b1;
    end else if (my_cmd && cmd_op == OP_STALL) begin
      stall_q <= cmd_i[`DBG_CMD_DATA_LSB];
      if (!cmd_i[`DBG_CMD_DATA_LSB]) begin
        bp_flag <= 1'b0;
      end
    end
  end

  assign cpu_stall_o = stall_q;

  // Read data sampled on the ack edge
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      rdata_q <= '0;
    end else if (cpu_stb_o && cpu_ack_i && !cpu_req.we) begin
      rdata_q <= cpu_data_i;
    end
  end

  // Output register, {read data, bp flag, stall}
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      out_sr <= '0;
    end else if (capture_dr_i && module_select_i) begin
      out_sr <= {rdata_q, bp_flag, stall_q};
    end else if (shift_dr_i && module_select_i) begin
      out_sr <= {tdi_i, out_sr[`DBG_OUT_LEN-1:1]};
    end
  end

  assign tdo_o = out_sr[0];

endmodule

/* hdl/dbg_top.sv */
//////////////////////////////////////////////////////////////////////
// Debug chain top
// Input shift register, module select and TDO mux for two modules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dbg_cfg.svh"

module dbg_top (
  input  logic                   tck_i,
  input  logic                   tlr_i,
  // TAP strobes and instruction flag
  input  logic                   tdi_i,
  output logic                   tdo_o,
  input  logic                   shift_dr_i,
  input  logic                   capture_dr_i,
  input  logic                   update_dr_i,
  input  logic                   debug_select_i,
  // System bus
  output logic                   bus_req_valid_o,
  input  logic                   bus_req_ready_i,
  output logic                   bus_we_o,
  output logic [`DBG_ADDR_W-1:0] bus_addr_o,
  output logic [`DBG_DATA_W-1:0] bus_wdata_o,
  input  logic                   bus_rsp_valid_i,
  input  logic [`DBG_DATA_W-1:0] bus_rdata_i,
  // Core
  input  logic                   cpu_bp_i,
  output logic                   cpu_stall_o,
  output logic                   cpu_stb_o,
  output logic                   cpu_we_o,
  output logic [`DBG_ADDR_W-1:0] cpu_addr_o,
  output logic [`DBG_DATA_W-1:0] cpu_data_o,
  input  logic                   cpu_ack_i,
  input  logic [`DBG_DATA_W-1:0] cpu_data_i
);

  import dbg_pkg::*;

  logic [`DBG_DATAREG_LEN-1:0] shift_reg;
  dbg_mod_id_e                 module_id;
  logic                        select_cmd;
  logic                        cmd_update;
  logic                        sel_bus;
  logic                        sel_cpu;
  logic                        tdo_bus;
  logic                        tdo_cpu;
  logic                        inhibit_bus;
  logic                        inhibit_cpu;

  //////////////////////////////////////////////////////////////////////
  // Shift register and module ID
  //////////////////////////////////////////////////////////////////////

  // LSB first, new bits enter at the top
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      shift_reg <= '0;
    end else if (debug_select_i && shift_dr_i) begin
      shift_reg <= {tdi_i, shift_reg[`DBG_DATAREG_LEN-1:1]};
    end
  end

  assign select_cmd = shift_reg[`DBG_SEL_BIT];
  assign cmd_update = debug_select_i && update_dr_i && !select_cmd;

  // A busy module keeps the chain pointed at itself
  always_ff @(posedge tck_i, posedge tlr_i) begin
    if (tlr_i) begin
      module_id <= ID_BUS;
    end else if (debug_select_i && update_dr_i && select_cmd &&
                 !(inhibit_bus || inhibit_cpu)) begin
      module_id <= dbg_mod_id_e'(
        shift_reg[`DBG_ID_MSB -: `DBG_MODULE_ID_LEN]);
    end
  end

  assign sel_bus = (module_id == ID_BUS);
  assign sel_cpu = (module_id == ID_CPU);

  // Reserved and unused codes drive TDO low
  always_comb begin
    case (module_id)
      ID_BUS:  tdo_o = tdo_bus;
      ID_CPU:  tdo_o = tdo_cpu;
      default: tdo_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Debug modules
  //////////////////////////////////////////////////////////////////////

  dbg_bus_module i_bus (
    .tck_i(tck_i), .tlr_i(tlr_i), .tdi_i(tdi_i), .tdo_o(tdo_bus),
    .shift_dr_i(shift_dr_i), .capture_dr_i(capture_dr_i),
    .cmd_update_i(cmd_update), .module_select_i(sel_bus),
    .cmd_i(shift_reg[`DBG_CMD_MSB:`DBG_CMD_LSB]), .inhibit_o(inhibit_bus),
    .bus_req_valid_o(bus_req_valid_o), .bus_req_ready_i(bus_req_ready_i),
    .bus_we_o(bus_we_o), .bus_addr_o(bus_addr_o), .bus_wdata_o(bus_wdata_o),
    .bus_rsp_valid_i(bus_rsp_valid_i), .bus_rdata_i(bus_rdata_i)
  );

  dbg_cpu_module i_cpu (
    .tck_i(tck_i), .tlr_i(tlr_i), .tdi_i(tdi_i), .tdo_o(tdo_cpu),
    .shift_dr_i(shift_dr_i), .capture_dr_i(capture_dr_i),
    .cmd_update_i(cmd_update), .module_select_i(sel_cpu),
    .cmd_i(shift_reg[`DBG_CMD_MSB:`DBG_CMD_LSB]), .inhibit_o(inhibit_cpu),
    .cpu_bp_i(cpu_bp_i), .cpu_stall_o(cpu_stall_o), .cpu_stb_o(cpu_stb_o),
    .cpu_we_o(cpu_we_o), .cpu_addr_o(cpu_addr_o), .cpu_data_o(cpu_data_o),
    .cpu_ack_i(cpu_ack_i), .cpu_data_i(cpu_data_i)
  );

endmodule

/* dv/tb_dbg_checks.sv */
//////////////////////////////////////////////////////////////////////
// Debug chain protocol checks
// Concurrent assertions on the bus and core handshakes of the DUT
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dbg_cfg.svh"

module tb_dbg_checks (
  input  logic                   tck_i,
  input  logic                   tlr_i,
  input  logic                   tdo_i,
  input  logic                   bus_req_valid_i,
  input  logic                   bus_req_ready_i,
  input  logic                   bus_we_i,
  input  logic [`DBG_ADDR_W-1:0] bus_addr_i,
  input  logic [`DBG_DATA_W-1:0] bus_wdata_i,
  input  logic                   cpu_bp_i,
  input  logic                   cpu_stall_i,
  input  logic                   cpu_stb_i,
  input  logic                   cpu_we_i,
  input  logic [`DBG_ADDR_W-1:0] cpu_addr_i,
  input  logic [`DBG_DATA_W-1:0] cpu_data_i,
  input  logic                   cpu_ack_i,
  output logic                   fail_o
);

  initial fail_o = 1'b0;

  task automatic raise_error(input string what);
    $display("%s", what);
    fail_o = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reset and known values
  //////////////////////////////////////////////////////////////////////

  // Outputs settle one edge after a reset cycle
  reset_idle: assert property (@(posedge tck_i)
    tlr_i |=> (!bus_req_valid_i && !cpu_stb_i && !cpu_stall_i))
    else raise_error("bus request, core strobe or stall not idle after reset");

  no_unknown: assert property (@(posedge tck_i) disable iff (tlr_i)
    !$isunknown({tdo_i, bus_req_valid_i, cpu_stb_i, cpu_stall_i}))
    else raise_error("TDO or a handshake output is unknown");

  //////////////////////////////////////////////////////////////////////
  // Bus side, held under back-pressure, dropped after the transfer
  //////////////////////////////////////////////////////////////////////

  bus_hold: assert property (@(posedge tck_i) disable iff (tlr_i)
    (bus_req_valid_i && !bus_req_ready_i) |=> (bus_req_valid_i &&
      $stable(bus_we_i) && $stable(bus_addr_i) && $stable(bus_wdata_i)))
    else raise_error("bus request changed while ready was low");

  bus_drop: assert property (@(posedge tck_i) disable iff (tlr_i)
    (bus_req_valid_i && bus_req_ready_i) |=> !bus_req_valid_i)
    else raise_error("bus request still valid after the transfer");

  //////////////////////////////////////////////////////////////////////
  // Core side
  //////////////////////////////////////////////////////////////////////

  // Strobe and fields held until ack
  cpu_hold: assert property (@(posedge tck_i) disable iff (tlr_i)
    (cpu_stb_i && !cpu_ack_i) |=> (cpu_stb_i &&
      $stable(cpu_we_i) && $stable(cpu_addr_i) && $stable(cpu_data_i)))
    else raise_error("core strobe or its fields changed before ack");

  cpu_drop: assert property (@(posedge tck_i) disable iff (tlr_i)
    (cpu_stb_i && cpu_ack_i) |=> !cpu_stb_i)
    else raise_error("core strobe did not fall one cycle after ack");

  // Register access only on a stalled core
  stb_stalled: assert property (@(posedge tck_i) disable iff (tlr_i)
    $rose(cpu_stb_i) |-> cpu_stall_i)
    else raise_error("core strobe raised while the core was running");

  bp_stall: assert property (@(posedge tck_i) disable iff (tlr_i)
    cpu_bp_i |=> cpu_stall_i)
    else raise_error("breakpoint did not stall the core");

endmodule

/* dv/tb_dbg_top.sv */
//////////////////////////////////////////////////////////////////////
// Debug chain testbench
// Command shifting, bus and core models, directed and random tests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "dbg_cfg.svh"

module tb_dbg_top;

  import dbg_pkg::*;

  // DUT inputs, all start at a defined value
  logic                   tck = 1'b0;
  logic                   tlr = 1'b1;
  logic                   tdi = 1'b0;
  logic                   shift_dr = 1'b0;
  logic                   capture_dr = 1'b0;
  logic                   update_dr = 1'b0;
  logic                   debug_select = 1'b1;
  logic                   bus_req_ready = 1'b0;
  logic                   bus_rsp_valid = 1'b0;
  logic [`DBG_DATA_W-1:0] bus_rdata = '0;
  logic                   cpu_bp = 1'b0;
  logic                   cpu_ack = 1'b0;
  logic [`DBG_DATA_W-1:0] cpu_rdata = '0;
  // DUT outputs
  logic                   tdo;
  logic                   bus_req_valid;
  logic                   bus_we;
  logic [`DBG_ADDR_W-1:0] bus_addr;
  logic [`DBG_DATA_W-1:0] bus_wdata;
  logic                   cpu_stall;
  logic                   cpu_stb;
  logic                   cpu_we;
  logic [`DBG_ADDR_W-1:0] cpu_addr;
  logic [`DBG_DATA_W-1:0] cpu_wdata;
  logic                   chk_fail;
  // Model state
  logic                   bus_hold = 1'b0;
  int                     rsp_wait = 0;
  int                     rsp_count = 0;
  logic [`DBG_DATA_W-1:0] bus_next_rdata = '0;
  int                     ack_wait = -1;

  always #50 tck = ~tck;

  dbg_top DUT (
    .tck_i(tck), .tlr_i(tlr), .tdi_i(tdi), .tdo_o(tdo),
    .shift_dr_i(shift_dr), .capture_dr_i(capture_dr), .update_dr_i(update_dr),
    .debug_select_i(debug_select),
    .bus_req_valid_o(bus_req_valid), .bus_req_ready_i(bus_req_ready),
    .bus_we_o(bus_we), .bus_addr_o(bus_addr), .bus_wdata_o(bus_wdata),
    .bus_rsp_valid_i(bus_rsp_valid), .bus_rdata_i(bus_rdata),
    .cpu_bp_i(cpu_bp), .cpu_stall_o(cpu_stall), .cpu_stb_o(cpu_stb),
    .cpu_we_o(cpu_we), .cpu_addr_o(cpu_addr), .cpu_data_o(cpu_wdata),
    .cpu_ack_i(cpu_ack), .cpu_data_i(cpu_rdata)
  );

  tb_dbg_checks i_checks (
    .tck_i(tck), .tlr_i(tlr), .tdo_i(tdo),
    .bus_req_valid_i(bus_req_valid), .bus_req_ready_i(bus_req_ready),
    .bus_we_i(bus_we), .bus_addr_i(bus_addr), .bus_wdata_i(bus_wdata),
    .cpu_bp_i(cpu_bp), .cpu_stall_i(cpu_stall), .cpu_stb_i(cpu_stb),
    .cpu_we_i(cpu_we), .cpu_addr_i(cpu_addr), .cpu_data_i(cpu_wdata),
    .cpu_ack_i(cpu_ack), .fail_o(chk_fail)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Core register contents, a function of the whole address
  function automatic logic [15:0] reg_rule(input logic [7:0] addr);
    return {addr ^ 8'hc3, ~addr};
  endfunction

  // Module command, opcode 30:28, address 27:20, data 19:4
  function automatic logic [31:0] module_cmd(input dbg_op_e op, input logic [7:0] addr,
                                             input logic [15:0] data);
    return {1'b0, op, addr, data, 4'h0};
  endfunction

  function automatic logic [31:0] select_cmd(input dbg_mod_id_e id);
    return {1'b1, id, 29'h0};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else abort_run($sformatf("FAILED %s: expected %0h, actual %0h", name, exp, act));
  endtask

  // 32 bits LSB first, then one update cycle
  task automatic shift_cmd(input logic [31:0] cmd);
    for (int i = 0; i < `DBG_DATAREG_LEN; i++) begin
      @(negedge tck);
      shift_dr = 1'b1;
      tdi      = cmd[i];
    end
    @(negedge tck);
    shift_dr  = 1'b0;
    update_dr = 1'b1;
    @(negedge tck);
    update_dr = 1'b0;
  endtask

  // Capture, then collect the output register from bit 0 up
  task automatic read_status(output logic [`DBG_OUT_LEN-1:0] bits);
    @(negedge tck);
    capture_dr = 1'b1;
    @(negedge tck);
    capture_dr = 1'b0;
    shift_dr   = 1'b1;
    tdi        = 1'b0;
    for (int i = 0; i < `DBG_OUT_LEN; i++) begin
      bits[i] = tdo;
      @(negedge tck);
    end
    shift_dr = 1'b0;
  endtask

  // Counter moves on the falling edge, polled on the rising one
  task automatic wait_bus_done(input int start);
    int n = 0;
    while (rsp_count == start && n < 100) begin
      @(posedge tck);
      n++;
    end
    if (rsp_count == start) begin
      abort_run("timeout waiting for the bus response");
    end
  endtask

  task automatic wait_cpu_done();
    int n = 0;
    while (cpu_stb && n < 20) begin
      @(negedge tck);
      n++;
    end
    if (cpu_stb) begin
      abort_run("timeout waiting for the core ack");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and core models
  //////////////////////////////////////////////////////////////////////

  // Random back-pressure, then a delayed response with random data
  always @(negedge tck) begin
    bus_req_ready = 1'b0;
    bus_rsp_valid = 1'b0;
    if (rsp_wait > 0) begin
      rsp_wait--;
      if (rsp_wait == 0) begin
        bus_rsp_valid = 1'b1;
        bus_rdata     = bus_next_rdata;
        rsp_count++;
      end
    end else if (bus_req_valid && !bus_hold && $urandom_range(0, 3) == 0) begin
      bus_req_ready  = 1'b1;
      rsp_wait       = $urandom_range(1, 6);
      bus_next_rdata = 16'($urandom);
    end
  end

  // Ack after 0 to 3 cycles
  always @(negedge tck) begin
    cpu_ack = 1'b0;
    if (cpu_stb) begin
      if (ack_wait < 0) begin
        ack_wait = $urandom_range(0, 3);
      end
      if (ack_wait == 0) begin
        cpu_ack   = 1'b1;
        cpu_rdata = reg_rule(cpu_addr);
        ack_wait  = -1;
      end else begin
        ack_wait--;
      end
    end
  end

  always @(posedge chk_fail) begin
    abort_run("protocol assertion failed");
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [`DBG_OUT_LEN-1:0] status;
    logic [7:0]              addr;
    logic [15:0]             data;
    int                      start;
    void'($urandom(33));
    repeat (4) @(negedge tck);
    tlr = 1'b0;
    @(negedge tck);
    expect_eq("reset outputs", 0, {bus_req_valid, cpu_stb, cpu_stall});

    // No select yet, so these writes only reach the bus if ID 0 is active
    repeat (6) begin
      addr  = 8'($urandom);
      data  = 16'($urandom);
      start = rsp_count;
      shift_cmd(module_cmd(OP_WRITE, addr, data));
      expect_eq("bus write", {2'b11, addr, data}, {bus_req_valid, bus_we, bus_addr, bus_wdata});
      wait_bus_done(start);
    end

    // Read held off, select for CPU while busy is dropped
    @(posedge tck);
    bus_hold = 1'b1;
    addr     = 8'($urandom);
    start    = rsp_count;
    shift_cmd(module_cmd(OP_READ, addr, 16'h0));
    expect_eq("bus read", {2'b10, addr, 16'h0}, {bus_req_valid, bus_we, bus_addr, bus_wdata});
    shift_cmd(select_cmd(ID_CPU));
    read_status(status);
    expect_eq("bus busy status", 1, status);
    @(posedge tck);
    bus_hold = 1'b0;
    wait_bus_done(start);
    read_status(status);
    expect_eq("bus read status", {bus_next_rdata, 2'b00}, status);

    // Breakpoint sets stall and the sticky flag
    shift_cmd(select_cmd(ID_CPU));
    @(negedge tck);
    cpu_bp = 1'b1;
    @(negedge tck);
    cpu_bp = 1'b0;
    expect_eq("breakpoint stall", 1, cpu_stall);
    read_status(status);
    expect_eq("breakpoint status", 3, status);
    shift_cmd(module_cmd(OP_STALL, 8'h00, 16'h0000));
    read_status(status);
    expect_eq("release status", 0, {cpu_stall, status});

    // Running core, access must not strobe
    shift_cmd(module_cmd(OP_READ, 8'h5a, 16'h0));
    repeat (8) begin
      @(negedge tck);
      expect_eq("running core strobe", 0, cpu_stb);
    end
    shift_cmd(module_cmd(OP_STALL, 8'h00, 16'h0001));
    expect_eq("stall command", 1, cpu_stall);
    repeat (4) begin
      addr = 8'($urandom);
      data = 16'($urandom);
      shift_cmd(module_cmd(OP_WRITE, addr, data));
      expect_eq("cpu write", {2'b11, addr, data}, {cpu_stb, cpu_we, cpu_addr, cpu_wdata});
      wait_cpu_done();
      addr = 8'($urandom);
      shift_cmd(module_cmd(OP_READ, addr, 16'h0));
      expect_eq("cpu read", {2'b10, addr, 16'h0}, {cpu_stb, cpu_we, cpu_addr, cpu_wdata});
      wait_cpu_done();
      read_status(status);
      expect_eq("cpu read status", {reg_rule(addr), 2'b01}, status);
    end

    // Reserved ID, stall bit would show if the CPU were still selected
    shift_cmd(select_cmd(ID_RSVD));
    read_status(status);
    expect_eq("reserved tdo", 0, status);

    if (!chk_fail) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abort_run("checker flagged an error during the run");
    end
  end

endmodule

/* tb.f */
+incdir+include
hdl/dbg_pkg.sv
hdl/dbg_req_slot.sv
hdl/dbg_bus_module.sv
hdl/dbg_cpu_module.sv
hdl/dbg_top.sv
dv/tb_dbg_checks.sv
dv/tb_dbg_top.sv

/* Bender.yml */
package:
  name: dbg_subsystem

sources:
  - include_dirs:
      - include
    files:
      - hdl/dbg_pkg.sv
      - hdl/dbg_req_slot.sv
      - hdl/dbg_bus_module.sv
      - hdl/dbg_cpu_module.sv
      - hdl/dbg_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_dbg_checks.sv
      - dv/tb_dbg_top.sv
